//--- dv/axil_ram_model.svh
// Reference model for the AXI4-lite RAM testbench with word storage under byte
// strobes and in-order queues of expected B and R responses
`ifndef AXIL_RAM_MODEL_SVH
`define AXIL_RAM_MODEL_SVH

// One expected response with zero data for B
typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [1:0]        resp;
    logic [DATA_W-1:0] data;
} exp_rsp_t;

// First byte address past the 512-word RAM
localparam logic [ADDR_W-1:0] TOP_ADDR = 12'h800;

logic [DATA_W-1:0] model_mem [512];
exp_rsp_t          r_exp_q [$];
exp_rsp_t          b_exp_q [$];

function automatic void clear_model();
    for (int i = 0; i < 512; i++) begin
        model_mem[i] = '0;
    end
endfunction

// Applied when the write is issued since writes complete in issue order
function automatic void apply_write(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                                    input logic [DATA_W-1:0] data,
                                    input logic [STRB_W-1:0] strb);
    exp_rsp_t rsp;
    rsp.id   = id;
    rsp.data = '0;
    rsp.resp = RESP_DECERR;
    if (addr < TOP_ADDR) begin
        rsp.resp = RESP_OKAY;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                model_mem[addr[10:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    end
    b_exp_q.push_back(rsp);
endfunction

// Out-of-range reads return zero data
function automatic void queue_read(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr);
    exp_rsp_t rsp;
    rsp.id   = id;
    rsp.resp = (addr < TOP_ADDR) ? RESP_OKAY : RESP_DECERR;
    rsp.data = (addr < TOP_ADDR) ? model_mem[addr[10:2]] : '0;
    r_exp_q.push_back(rsp);
endfunction

`endif

//--- dv/axil_ram_tb.sv
// Randomized testbench for the AXI4-lite RAM slave that checks B and R
// responses in order against the reference model
`timescale 1ns/1ps
`default_nettype none

module axil_ram_tb
    import axil_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int HOLD_CYCLES  = 80;
    // About 100 transactions, each well under 100 cycles even with random ready
    localparam int CYCLE_LIMIT  = 20000;

    logic              aclk    = 1'b0;
    logic              aresetn = 1'b0;
    logic              srst    = 1'b0;
    logic              arvalid = 1'b0;
    logic [ADDR_W-1:0] araddr  = '0;
    logic [ID_W-1:0]   arid    = '0;
    logic              awvalid = 1'b0;
    logic [ADDR_W-1:0] awaddr  = '0;
    logic [ID_W-1:0]   awid    = '0;
    logic              wvalid  = 1'b0;
    logic [DATA_W-1:0] wdata   = '0;
    logic [STRB_W-1:0] wstrb   = '0;
    logic              bready  = 1'b0;
    logic              rready  = 1'b0;
    logic              arready;
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic [ID_W-1:0]   bid;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
    logic [ID_W-1:0]   rid;

    integer seed         = 94963;
    int     errors       = 0;
    int     checks       = 0;
    int     cycle_cnt    = 0;
    logic   hold_ready   = 1'b0;
    logic   saw_ar_stall = 1'b0;
    logic   saw_aw_stall = 1'b0;

    `include "axil_ram_model.svh"

    axil_ram_top axil_ram_top_inst (.*);

    initial begin
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    always @(posedge aclk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt == CYCLE_LIMIT);
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAIL");
        $finish;
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic expect_value(input string name, input logic [DATA_W-1:0] got,
                                input logic [DATA_W-1:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_idle_outputs();
        expect_value("rvalid", rvalid, 0);
        expect_value("bvalid", bvalid, 0);
        expect_value("arready", arready, 1);
        expect_value("awready", awready, 1);
        expect_value("wready", wready, 1);
    endtask

    task automatic take_r_beat();
        exp_rsp_t want;
        assert (r_exp_q.size() != 0) else begin
            errors++;
            $display("An R response arrived with no read outstanding");
        end
        if (r_exp_q.size() != 0) begin
            want = r_exp_q.pop_front();
            expect_value("rid", rid, want.id);
            expect_value("rresp", rresp, want.resp);
            expect_value("rdata", rdata, want.data);
        end
    endtask

    task automatic take_b_beat();
        exp_rsp_t want;
        assert (b_exp_q.size() != 0) else begin
            errors++;
            $display("A B response arrived with no write outstanding");
        end
        if (b_exp_q.size() != 0) begin
            want = b_exp_q.pop_front();
            expect_value("bid", bid, want.id);
            expect_value("bresp", bresp, want.resp);
        end
    endtask

    // Ready toggling and response capture ahead of the transfer edge
    initial begin
        forever begin
            @(negedge aclk);
            rready = !hold_ready && (($random(seed) & 3) != 0);
            bready = !hold_ready && (($random(seed) & 3) != 0);
            if (hold_ready && !arready) saw_ar_stall = 1'b1;
            if (hold_ready && !awready) saw_aw_stall = 1'b1;
            if (rvalid && rready) take_r_beat();
            if (bvalid && bready) take_b_beat();
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    function automatic logic [ADDR_W-1:0] rand_word_addr();
        return {1'b0, 9'($random(seed)), 2'b00};
    endfunction

    // Valid and payload hold until the edge that finds ready high
    task automatic send_ar(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr);
        arvalid = 1'b1;
        arid    = id;
        araddr  = addr;
        while (!arready) @(negedge aclk);
        @(negedge aclk);
        arvalid = 1'b0;
    endtask

    task automatic send_aw(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr);
        awvalid = 1'b1;
        awid    = id;
        awaddr  = addr;
        while (!awready) @(negedge aclk);
        @(negedge aclk);
        awvalid = 1'b0;
    endtask

    task automatic send_w(input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
        wvalid = 1'b1;
        wdata  = data;
        wstrb  = strb;
        while (!wready) @(negedge aclk);
        @(negedge aclk);
        wvalid = 1'b0;
    endtask

    task automatic issue_read(input logic [ADDR_W-1:0] addr);
        logic [ID_W-1:0] id;
        id = 4'($random(seed));
        queue_read(id, addr);
        send_ar(id, addr);
    endtask

    // AW and W go out together, each side waits for its own ready
    task automatic issue_write(input logic [ADDR_W-1:0] addr, input logic [STRB_W-1:0] strb);
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        id   = 4'($random(seed));
        data = 32'($random(seed));
        apply_write(id, addr, data, strb);
        fork
            send_aw(id, addr);
            send_w(data, strb);
        join
    endtask

    task automatic wait_drained();
        while (r_exp_q.size() != 0 || b_exp_q.size() != 0) @(negedge aclk);
        @(negedge aclk);
    endtask

    initial begin
        logic [ADDR_W-1:0] addrs [$];
        logic [ID_W-1:0]   ids [$];
        logic [DATA_W-1:0] datas [$];
        logic [ADDR_W-1:0] a;
        clear_model();
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        check_idle_outputs();

        // Full-word writes, then reads of the same words
        for (int i = 0; i < 16; i++) begin
            addrs.push_back(rand_word_addr());
            issue_write(addrs[i], 4'hF);
        end
        wait_drained();
        foreach (addrs[i]) issue_read(addrs[i]);
        wait_drained();

        // Partial writes merged into one word
        a = rand_word_addr();
        repeat (6) issue_write(a, 4'($random(seed)));
        wait_drained();
        issue_read(a);
        wait_drained();

        // Writes above the RAM must leave the aliased low words as they were
        addrs.delete();
        for (int i = 0; i < 4; i++) begin
            addrs.push_back(rand_word_addr());
            issue_write(addrs[i] | TOP_ADDR, 4'hF);
            issue_read(addrs[i] | TOP_ADDR);
        end
        wait_drained();
        foreach (addrs[i]) issue_read(addrs[i]);
        wait_drained();

        // Writes to the upper half and reads from the lower half with R and B held off
        hold_ready = 1'b1;
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    issue_write({2'b01, 8'($random(seed)), 2'b00}, 4'hF);
                end
            end
            begin
                for (int i = 0; i < 8; i++) begin
                    issue_read({2'b00, 8'($random(seed)), 2'b00});
                end
            end
            begin
                repeat (HOLD_CYCLES) @(negedge aclk);
                hold_ready = 1'b0;
            end
        join
        wait_drained();
        assert (saw_ar_stall && saw_aw_stall) else begin
            errors++;
            $display("arready or awready never fell while responses were held off");
        end

        // AW and W streams run apart, so either side may lead by several beats
        addrs.delete();
        for (int i = 0; i < 12; i++) begin
            addrs.push_back(rand_word_addr());
            ids.push_back(4'($random(seed)));
            datas.push_back(32'($random(seed)));
            apply_write(ids[i], addrs[i], datas[i], 4'hF);
        end
        fork
            foreach (addrs[i]) begin
                repeat ($random(seed) & 3) @(negedge aclk);
                send_aw(ids[i], addrs[i]);
            end
            foreach (addrs[i]) begin
                repeat ($random(seed) & 3) @(negedge aclk);
                send_w(datas[i], 4'hF);
            end
        join
        wait_drained();

        // Requests left queued with R and B held off, then dropped by srst
        hold_ready = 1'b1;
        for (int i = 0; i < 4; i++) begin
            issue_read(rand_word_addr());
        end
        for (int i = 0; i < 5; i++) begin
            issue_write(rand_word_addr() | TOP_ADDR, 4'hF);
        end
        while (!(rvalid && bvalid && !arready && !awready && !wready)) @(negedge aclk);
        srst = 1'b1;
        @(negedge aclk);
        srst = 1'b0;
        r_exp_q.delete();
        b_exp_q.delete();
        check_idle_outputs();
        hold_ready = 1'b0;

        // Stored words survive srst
        foreach (addrs[i]) issue_read(addrs[i]);
        wait_drained();

        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_cnt);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/axil_pkg.sv
// AXI4-lite bus widths, response codes and the packed channel payloads
// shared by the RAM slave engines and the top level

`default_nettype none

package axil_pkg;

    //////////////////////////////
    // Bus widths
    //////////////////////////////

    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;

    // Response codes, only OKAY and DECERR are ever produced
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    //////////////////////////////
    // Channel payloads
    //////////////////////////////

    // AR and AW request, 16 bits
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
    } axil_addr_t;

    // W beat, 36 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axil_wdata_t;

    // B response, also the id/resp part of R
    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } axil_resp_t;

endpackage

`default_nettype wire

//--- logic/axil_ram_top.sv
// AXI4-lite RAM slave top level with flat bus ports; packs the channels
// into structs and joins the read and write engines to the RAM

`timescale 1ns/1ps
`default_nettype none

module axil_ram_top
    import axil_pkg::*;
    import ram_pkg::*;
(
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              srst,
    // Read address
    input  logic              arvalid,
    output logic              arready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic [ID_W-1:0]   arid,
    // Write address
    input  logic              awvalid,
    output logic              awready,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic [ID_W-1:0]   awid,
    // Write data
    input  logic              wvalid,
    output logic              wready,
    input  logic [DATA_W-1:0] wdata,
    input  logic [STRB_W-1:0] wstrb,
    // Write response
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    output logic [ID_W-1:0]   bid,
    // Read data
    output logic              rvalid,
    input  logic              rready,
    output logic [DATA_W-1:0] rdata,
    output logic [1:0]        rresp,
    output logic [ID_W-1:0]   rid
);

    axil_addr_t            ar_req;
    axil_addr_t            aw_req;
    axil_wdata_t           w_beat;
    axil_resp_t            r_resp;
    axil_resp_t            b_resp;
    logic                  we;
    logic [WORD_IDX_W-1:0] wr_idx;
    logic [DATA_W-1:0]     wr_data;
    logic [STRB_W-1:0]     wr_strb;
    logic [WORD_IDX_W-1:0] rd_idx;
    logic [DATA_W-1:0]     rd_data;

    //////////////////////////////
    // Channel packing
    //////////////////////////////

    assign ar_req = '{id: arid, addr: araddr};
    assign aw_req = '{id: awid, addr: awaddr};
    assign w_beat = '{data: wdata, strb: wstrb};

    assign rid   = r_resp.id;
    assign rresp = r_resp.resp;
    assign bid   = b_resp.id;
    assign bresp = b_resp.resp;

    //////////////////////////////
    // Engines and storage
    //////////////////////////////

    axil_read_engine read_engine_inst (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .srst     (srst),
        .ar_valid (arvalid),
        .ar_ready (arready),
        .ar_req   (ar_req),
        .r_valid  (rvalid),
        .r_ready  (rready),
        .r_data   (rdata),
        .r_resp   (r_resp),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data)
    );

    axil_write_engine write_engine_inst (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .srst     (srst),
        .aw_valid (awvalid),
        .aw_ready (awready),
        .aw_req   (aw_req),
        .w_valid  (wvalid),
        .w_ready  (wready),
        .w_beat   (w_beat),
        .b_valid  (bvalid),
        .b_ready  (bready),
        .b_resp   (b_resp),
        .we       (we),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb)
    );

    // srst leaves the stored words alone
    ram_array ram_inst (
        .aclk    (aclk),
        .aresetn (aresetn),
        .we      (we),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

//--- logic/axil_read_engine.sv
// AXI4-lite read side that buffers AR requests and answers them in order on R
// after an LFSR-driven wait of 0 to 3 cycles per request

`timescale 1ns/1ps
`default_nettype none

module axil_read_engine
    import axil_pkg::*;
    import ram_pkg::*;
(
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  srst,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  axil_addr_t            ar_req,
    output logic                  r_valid,
    input  logic                  r_ready,
    output logic [DATA_W-1:0]     r_data,
    output axil_resp_t            r_resp,
    output logic [WORD_IDX_W-1:0] rd_idx,
    input  logic [DATA_W-1:0]     rd_data
);

    axil_addr_t            head;
    logic                  fifo_empty;
    logic                  fifo_full;
    logic                  r_done;
    logic                  in_range;
    logic                  busy;
    logic [MAX_WAIT_W-1:0] wait_cnt;
    logic [LFSR_W-1:0]     lfsr;

    //////////////////////////////
    // Request buffer
    //////////////////////////////

    // A request enters the FIFO only on an AR transfer
    sc_fifo #(
        .payload_t (axil_addr_t),
        .DEPTH     (RD_FIFO_DEPTH)
    ) ar_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .srst     (srst),
        .push     (ar_valid & ar_ready),
        .data_in  (ar_req),
        .full     (fifo_full),
        .pop      (r_done),
        .data_out (head),
        .empty    (fifo_empty)
    );

    assign ar_ready = ~fifo_full;
    assign r_done   = r_valid & r_ready;

    // Word index and decode of the request at the head
    assign rd_idx   = head.addr[ADDR_LSB +: WORD_IDX_W];
    assign in_range = (head.addr[ADDR_W-1:ADDR_LSB] < RAM_DEPTH);

    //////////////////////////////
    // Wait counter and R valid
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy     <= 1'b0;
            wait_cnt <= '0;
            r_valid  <= 1'b0;
            lfsr     <= LFSR_SEED;
        end else if (srst) begin
            busy     <= 1'b0;
            wait_cnt <= '0;
            r_valid  <= 1'b0;
            lfsr     <= LFSR_SEED;
        end else begin
            if (!busy && !r_valid && !fifo_empty) begin
                busy     <= 1'b1;
                wait_cnt <= lfsr[MAX_WAIT_W-1:0];
            end else if (busy) begin
                if (wait_cnt == '0) begin
                    busy    <= 1'b0;
                    r_valid <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
            // Next wait value is drawn once per completed response
            if (r_done) begin
                r_valid <= 1'b0;
                lfsr    <= {lfsr[LFSR_W-2:0], ^(lfsr & LFSR_TAPS)};
            end
        end
    end

    // Response payload is captured as the wait ends and holds under back-pressure
    always_ff @(posedge aclk) begin
        if (busy && wait_cnt == '0) begin
            r_data      <= in_range ? rd_data : '0;
            r_resp.id   <= head.id;
            r_resp.resp <= in_range ? RESP_OKAY : RESP_DECERR;
        end
    end

endmodule

`default_nettype wire

//--- logic/axil_write_engine.sv
// AXI4-lite write side that buffers AW and W separately, pairs them in order,
// writes the RAM and returns one B response per pair

`timescale 1ns/1ps
`default_nettype none

module axil_write_engine
    import axil_pkg::*;
    import ram_pkg::*;
(
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  srst,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axil_addr_t            aw_req,
    input  logic                  w_valid,
    output logic                  w_ready,
    input  axil_wdata_t           w_beat,
    output logic                  b_valid,
    input  logic                  b_ready,
    output axil_resp_t            b_resp,
    output logic                  we,
    output logic [WORD_IDX_W-1:0] wr_idx,
    output logic [DATA_W-1:0]     wr_data,
    output logic [STRB_W-1:0]     wr_strb
);

    axil_addr_t  aw_head;
    axil_wdata_t w_head;
    logic        aw_empty;
    logic        aw_full;
    logic        w_empty;
    logic        w_full;
    logic        b_free;
    logic        pair_fire;
    logic        in_range;

    //////////////////////////////
    // AW and W buffers
    //////////////////////////////

    // Each FIFO takes an entry only on a transfer of its own channel
    sc_fifo #(
        .payload_t (axil_addr_t),
        .DEPTH     (WR_FIFO_DEPTH)
    ) aw_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .srst     (srst),
        .push     (aw_valid & aw_ready),
        .data_in  (aw_req),
        .full     (aw_full),
        .pop      (pair_fire),
        .data_out (aw_head),
        .empty    (aw_empty)
    );

    sc_fifo #(
        .payload_t (axil_wdata_t),
        .DEPTH     (WR_FIFO_DEPTH)
    ) w_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .srst     (srst),
        .push     (w_valid & w_ready),
        .data_in  (w_beat),
        .full     (w_full),
        .pop      (pair_fire),
        .data_out (w_head),
        .empty    (w_empty)
    );

    assign aw_ready = ~aw_full;
    assign w_ready  = ~w_full;

    //////////////////////////////
    // Pairing and RAM write
    //////////////////////////////

    // B register can take a new response if empty or draining this cycle
    assign b_free    = ~b_valid | b_ready;
    assign pair_fire = ~aw_empty & ~w_empty & b_free;
    assign in_range  = (aw_head.addr[ADDR_W-1:ADDR_LSB] < RAM_DEPTH);

    // Out-of-range writes are dropped and answered with DECERR only
    assign we      = pair_fire & in_range;
    assign wr_idx  = aw_head.addr[ADDR_LSB +: WORD_IDX_W];
    assign wr_data = w_head.data;
    assign wr_strb = w_head.strb;

    // B channel
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            b_valid <= 1'b0;
        end else if (srst) begin
            b_valid <= 1'b0;
        end else if (pair_fire) begin
            b_valid <= 1'b1;
        end else if (b_ready) begin
            b_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (pair_fire) begin
            b_resp.id   <= aw_head.id;
            b_resp.resp <= in_range ? RESP_OKAY : RESP_DECERR;
        end
    end

endmodule

`default_nettype wire

//--- logic/ram_array.sv
// Word-addressed RAM, one byte-enabled write port and one combinational
// read port; contents are zeroed by aresetn only

`timescale 1ns/1ps
`default_nettype none

module ram_array
    import axil_pkg::*;
    import ram_pkg::*;
(
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  we,
    input  logic [WORD_IDX_W-1:0] wr_idx,
    input  logic [DATA_W-1:0]     wr_data,
    input  logic [STRB_W-1:0]     wr_strb,
    input  logic [WORD_IDX_W-1:0] rd_idx,
    output logic [DATA_W-1:0]     rd_data
);

    logic [DATA_W-1:0] mem [RAM_DEPTH];

    // Range checks live in the engines, the index is always in bounds here
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < RAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            // Only lanes with their strobe set are touched
            for (int b = 0; b < STRB_W; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    assign rd_data = mem[rd_idx];

endmodule

`default_nettype wire

//--- logic/ram_pkg.sv
// Memory geometry, request FIFO depths and read-wait generator constants
// for the AXI4-lite RAM slave

`default_nettype none

package ram_pkg;

    // 512 words of 32 bits, byte addresses 0x000 to 0x7FF
    localparam int RAM_DEPTH  = 512;
    localparam int WORD_IDX_W = 9;
    localparam int ADDR_LSB   = 2;

    // Outstanding request buffering
    localparam int RD_FIFO_DEPTH = 4;
    localparam int WR_FIFO_DEPTH = 4;

    // Read wait generator, x^8 + x^6 + x^5 + x^4 + 1
    localparam int         LFSR_W     = 8;
    localparam logic [7:0] LFSR_SEED  = 8'hA5;
    localparam logic [7:0] LFSR_TAPS  = 8'hB8;
    localparam int         MAX_WAIT_W = 2;

endpackage

`default_nettype wire

//--- logic/sc_fifo.sv
// Single-clock FIFO with a type-parameterized payload
// Head is visible combinationally on data_out while empty is low

`timescale 1ns/1ps
`default_nettype none

module sc_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     srst,
    input  logic     push,
    input  payload_t data_in,
    output logic     full,
    input  logic     pop,
    output payload_t data_out,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic             pop_ok;

    // A full FIFO still takes a push when the head leaves in the same cycle
    assign pop_ok  = pop & ~empty;
    assign push_ok = push & (~full | pop_ok);

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign data_out = mem[rd_ptr];

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge aclk) begin
        if (push_ok) begin
            mem[wr_ptr] <= data_in;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI4-lite RAM testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module axil_ram_tb \
    -Mdir obj_dir \
    -f sources.f

./obj_dir/Vaxil_ram_tb | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

//--- sources.f
+incdir+dv
logic/axil_pkg.sv
logic/ram_pkg.sv
logic/sc_fifo.sv
logic/ram_array.sv
logic/axil_read_engine.sv
logic/axil_write_engine.sv
logic/axil_ram_top.sv
dv/axil_ram_tb.sv
